//--- design/edge_eval.sv
`timescale 1ns/100ps
`default_nettype none

module edge_eval (
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic                    i_go,
    input  wire raster_geom_pkg::coord_t i_ax,
    input  wire raster_geom_pkg::coord_t i_ay,
    input  wire raster_geom_pkg::coord_t i_bx,
    input  wire raster_geom_pkg::coord_t i_by,
    input  wire raster_geom_pkg::coord_t i_px,
    input  wire raster_geom_pkg::coord_t i_py,
    output logic                         o_done,
    output raster_geom_pkg::edge_val_t   o_val,
    output raster_geom_pkg::coord_t      o_dx,
    output raster_geom_pkg::coord_t      o_dy
);

    raster_geom_pkg::edge_val_t ab_x;
    raster_geom_pkg::edge_val_t ab_y;
    raster_geom_pkg::edge_val_t ap_x;
    raster_geom_pkg::edge_val_t ap_y;
    raster_geom_pkg::edge_val_t prod_x;
    raster_geom_pkg::edge_val_t prod_y;

    // Differences sign-extended first so the products keep full width
    always_comb begin
        ab_x   = raster_geom_pkg::edge_val_t'(i_bx) - raster_geom_pkg::edge_val_t'(i_ax);
        ab_y   = raster_geom_pkg::edge_val_t'(i_by) - raster_geom_pkg::edge_val_t'(i_ay);
        ap_x   = raster_geom_pkg::edge_val_t'(i_px) - raster_geom_pkg::edge_val_t'(i_ax);
        ap_y   = raster_geom_pkg::edge_val_t'(i_py) - raster_geom_pkg::edge_val_t'(i_ay);
        prod_x = ap_x * ab_y;
        prod_y = ap_y * ab_x;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_done <= 1'b0;
        end else begin
            o_done <= i_go;
        end
    end

    // Results stay put until the next triangle
    always_ff @(posedge clk) begin
        if (i_go) begin
            o_val <= prod_x - prod_y;
            o_dx  <= raster_geom_pkg::coord_t'(ab_y);
            o_dy  <= raster_geom_pkg::coord_t'(-ab_x);
        end
    end

endmodule

`default_nettype wire

//--- design/raster_geom_pkg.sv
`default_nettype none
`include "raster_params.svh"

package raster_geom_pkg;

    typedef logic signed [`RS_COORD_W-1:0] coord_t;

    // Edge function values and doubled area need the full product width
    typedef logic signed [2*`RS_COORD_W-1:0] edge_val_t;

    // Role of each edge lane, in lane order
    typedef enum logic [$clog2(`RS_NUM_LANES)-1:0] {
        LANE_E0   = 0,
        LANE_E1   = 1,
        LANE_E2   = 2,
        LANE_AREA = 3
    } lane_t;

endpackage

`default_nettype wire

//--- design/raster_params.svh
`ifndef RASTER_PARAMS_SVH
`define RASTER_PARAMS_SVH

// Signed screen coordinate width
`define RS_COORD_W 12

// Screen size in pixels
`define RS_SCREEN_W 320
`define RS_SCREEN_H 320

`define RS_ID_W 16

// Three edges plus the area lane
`define RS_NUM_LANES 4

`endif

//--- design/raster_seq_pkg.sv
`default_nettype none
`include "raster_params.svh"

package raster_seq_pkg;

    typedef logic [`RS_ID_W-1:0] tri_id_t;

    // WAIT is the one-cycle retire slot after an emit or a drop
    typedef enum logic [1:0] {
        EMIT_IDLE,
        EMIT_WAIT,
        EMIT_HOLD
    } emit_state_t;

endpackage

`default_nettype wire

//--- design/raster_setup.sv
`timescale 1ns/100ps
`default_nettype none
`include "raster_params.svh"

module raster_setup (
    input  wire logic                    clk,
    input  wire logic                    rstn,
    output logic                         o_ready,
    input  wire logic                    i_next,
    input  wire raster_geom_pkg::coord_t i_v0_x,
    input  wire raster_geom_pkg::coord_t i_v0_y,
    input  wire raster_geom_pkg::coord_t i_v1_x,
    input  wire raster_geom_pkg::coord_t i_v1_y,
    input  wire raster_geom_pkg::coord_t i_v2_x,
    input  wire raster_geom_pkg::coord_t i_v2_y,
    input  wire logic                    i_triangle_dv,
    input  wire logic                    i_triangle_last,
    output raster_geom_pkg::coord_t      o_bb_min_x,
    output raster_geom_pkg::coord_t      o_bb_min_y,
    output raster_geom_pkg::coord_t      o_bb_max_x,
    output raster_geom_pkg::coord_t      o_bb_max_y,
    output raster_geom_pkg::edge_val_t   o_edge_val0,
    output raster_geom_pkg::edge_val_t   o_edge_val1,
    output raster_geom_pkg::edge_val_t   o_edge_val2,
    output raster_geom_pkg::coord_t      o_edge_dx0,
    output raster_geom_pkg::coord_t      o_edge_dx1,
    output raster_geom_pkg::coord_t      o_edge_dx2,
    output raster_geom_pkg::coord_t      o_edge_dy0,
    output raster_geom_pkg::coord_t      o_edge_dy1,
    output raster_geom_pkg::coord_t      o_edge_dy2,
    output raster_seq_pkg::tri_id_t      o_id,
    output logic                         o_dv,
    output logic                         o_last,
    output logic                         o_finished_with_cull
);

    logic                       lane_go;
    raster_geom_pkg::coord_t    lane_ax [`RS_NUM_LANES];
    raster_geom_pkg::coord_t    lane_ay [`RS_NUM_LANES];
    raster_geom_pkg::coord_t    lane_bx [`RS_NUM_LANES];
    raster_geom_pkg::coord_t    lane_by [`RS_NUM_LANES];
    raster_geom_pkg::coord_t    lane_px [`RS_NUM_LANES];
    raster_geom_pkg::coord_t    lane_py [`RS_NUM_LANES];
    logic                       lane_done [`RS_NUM_LANES];
    raster_geom_pkg::edge_val_t lane_val [`RS_NUM_LANES];
    raster_geom_pkg::coord_t    lane_dx [`RS_NUM_LANES];
    raster_geom_pkg::coord_t    lane_dy [`RS_NUM_LANES];
    raster_geom_pkg::edge_val_t edge_val [3];
    raster_geom_pkg::coord_t    edge_dx [3];
    raster_geom_pkg::coord_t    edge_dy [3];
    raster_geom_pkg::coord_t    bb_min_x;
    raster_geom_pkg::coord_t    bb_min_y;
    raster_geom_pkg::coord_t    bb_max_x;
    raster_geom_pkg::coord_t    bb_max_y;
    logic                       bb_valid;
    logic                       tri_last;
    logic                       retire;

    tri_capture u_tri_capture (
        .clk             (clk),
        .rstn            (rstn),
        .i_triangle_dv   (i_triangle_dv),
        .i_triangle_last (i_triangle_last),
        .i_v0_x          (i_v0_x),
        .i_v0_y          (i_v0_y),
        .i_v1_x          (i_v1_x),
        .i_v1_y          (i_v1_y),
        .i_v2_x          (i_v2_x),
        .i_v2_y          (i_v2_y),
        .i_retire        (retire),
        .o_ready         (o_ready),
        .o_lane_go       (lane_go),
        .o_lane_ax       (lane_ax),
        .o_lane_ay       (lane_ay),
        .o_lane_bx       (lane_bx),
        .o_lane_by       (lane_by),
        .o_lane_px       (lane_px),
        .o_lane_py       (lane_py),
        .o_bb_min_x      (bb_min_x),
        .o_bb_min_y      (bb_min_y),
        .o_bb_max_x      (bb_max_x),
        .o_bb_max_y      (bb_max_y),
        .o_bb_valid      (bb_valid),
        .o_last          (tri_last)
    );

    for (genvar k = 0; k < `RS_NUM_LANES; k++) begin : g_lane
        edge_eval u_edge_eval (
            .clk    (clk),
            .rstn   (rstn),
            .i_go   (lane_go),
            .i_ax   (lane_ax[k]),
            .i_ay   (lane_ay[k]),
            .i_bx   (lane_bx[k]),
            .i_by   (lane_by[k]),
            .i_px   (lane_px[k]),
            .i_py   (lane_py[k]),
            .o_done (lane_done[k]),
            .o_val  (lane_val[k]),
            .o_dx   (lane_dx[k]),
            .o_dy   (lane_dy[k])
        );
    end

    for (genvar e = 0; e < 3; e++) begin : g_edge
        assign edge_val[e] = lane_val[e];
        assign edge_dx[e]  = lane_dx[e];
        assign edge_dy[e]  = lane_dy[e];
    end

    // Lanes run in lockstep, lane 0 done stands for all of them
    tri_emit u_tri_emit (
        .clk                  (clk),
        .rstn                 (rstn),
        .i_lane_done          (lane_done[0]),
        .i_area               (lane_val[raster_geom_pkg::LANE_AREA]),
        .i_edge_val           (edge_val),
        .i_edge_dx            (edge_dx),
        .i_edge_dy            (edge_dy),
        .i_bb_min_x           (bb_min_x),
        .i_bb_min_y           (bb_min_y),
        .i_bb_max_x           (bb_max_x),
        .i_bb_max_y           (bb_max_y),
        .i_bb_valid           (bb_valid),
        .i_last               (tri_last),
        .i_next               (i_next),
        .o_retire             (retire),
        .o_bb_min_x           (o_bb_min_x),
        .o_bb_min_y           (o_bb_min_y),
        .o_bb_max_x           (o_bb_max_x),
        .o_bb_max_y           (o_bb_max_y),
        .o_edge_val0          (o_edge_val0),
        .o_edge_val1          (o_edge_val1),
        .o_edge_val2          (o_edge_val2),
        .o_edge_dx0           (o_edge_dx0),
        .o_edge_dx1           (o_edge_dx1),
        .o_edge_dx2           (o_edge_dx2),
        .o_edge_dy0           (o_edge_dy0),
        .o_edge_dy1           (o_edge_dy1),
        .o_edge_dy2           (o_edge_dy2),
        .o_id                 (o_id),
        .o_dv                 (o_dv),
        .o_last               (o_last),
        .o_finished_with_cull (o_finished_with_cull)
    );

endmodule

`default_nettype wire

//--- design/tri_capture.sv
`timescale 1ns/100ps
`default_nettype none
`include "raster_params.svh"

module tri_capture (
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic                    i_triangle_dv,
    input  wire logic                    i_triangle_last,
    input  wire raster_geom_pkg::coord_t i_v0_x,
    input  wire raster_geom_pkg::coord_t i_v0_y,
    input  wire raster_geom_pkg::coord_t i_v1_x,
    input  wire raster_geom_pkg::coord_t i_v1_y,
    input  wire raster_geom_pkg::coord_t i_v2_x,
    input  wire raster_geom_pkg::coord_t i_v2_y,
    input  wire logic                    i_retire,
    output logic                         o_ready,
    output logic                         o_lane_go,
    output raster_geom_pkg::coord_t      o_lane_ax [`RS_NUM_LANES],
    output raster_geom_pkg::coord_t      o_lane_ay [`RS_NUM_LANES],
    output raster_geom_pkg::coord_t      o_lane_bx [`RS_NUM_LANES],
    output raster_geom_pkg::coord_t      o_lane_by [`RS_NUM_LANES],
    output raster_geom_pkg::coord_t      o_lane_px [`RS_NUM_LANES],
    output raster_geom_pkg::coord_t      o_lane_py [`RS_NUM_LANES],
    output raster_geom_pkg::coord_t      o_bb_min_x,
    output raster_geom_pkg::coord_t      o_bb_min_y,
    output raster_geom_pkg::coord_t      o_bb_max_x,
    output raster_geom_pkg::coord_t      o_bb_max_y,
    output logic                         o_bb_valid,
    output logic                         o_last
);

    logic                    busy;
    logic                    accept;
    raster_geom_pkg::coord_t vx [3];
    raster_geom_pkg::coord_t vy [3];
    raster_geom_pkg::coord_t raw_min_x;
    raster_geom_pkg::coord_t raw_min_y;
    raster_geom_pkg::coord_t raw_max_x;
    raster_geom_pkg::coord_t raw_max_y;
    raster_geom_pkg::coord_t clip_min_x;
    raster_geom_pkg::coord_t clip_min_y;
    raster_geom_pkg::coord_t clip_max_x;
    raster_geom_pkg::coord_t clip_max_y;

    function automatic raster_geom_pkg::coord_t min3(input raster_geom_pkg::coord_t v [3]);
        raster_geom_pkg::coord_t m;
        m = (v[0] < v[1]) ? v[0] : v[1];
        return (m < v[2]) ? m : v[2];
    endfunction

    function automatic raster_geom_pkg::coord_t max3(input raster_geom_pkg::coord_t v [3]);
        raster_geom_pkg::coord_t m;
        m = (v[0] > v[1]) ? v[0] : v[1];
        return (m > v[2]) ? m : v[2];
    endfunction

    assign vx = '{i_v0_x, i_v1_x, i_v2_x};
    assign vy = '{i_v0_y, i_v1_y, i_v2_y};

    // Box of the incoming vertices, clamped to the screen
    always_comb begin
        raw_min_x  = min3(vx);
        raw_min_y  = min3(vy);
        raw_max_x  = max3(vx);
        raw_max_y  = max3(vy);
        clip_min_x = (raw_min_x < 0) ? '0 : raw_min_x;
        clip_min_y = (raw_min_y < 0) ? '0 : raw_min_y;
        clip_max_x = (raw_max_x > `RS_SCREEN_W) ?
                     raster_geom_pkg::coord_t'(`RS_SCREEN_W) : raw_max_x;
        clip_max_y = (raw_max_y > `RS_SCREEN_H) ?
                     raster_geom_pkg::coord_t'(`RS_SCREEN_H) : raw_max_y;
    end

    assign accept  = i_triangle_dv && !busy;
    assign o_ready = !busy;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy       <= 1'b0;
            o_lane_go  <= 1'b0;
            o_bb_valid <= 1'b0;
            o_last     <= 1'b0;
        end else begin
            o_lane_go <= accept;
            if (accept) begin
                busy       <= 1'b1;
                o_bb_valid <= (clip_min_x <= clip_max_x) && (clip_min_y <= clip_max_y);
                o_last     <= i_triangle_last;
            end else if (i_retire) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_bb_min_x <= clip_min_x;
            o_bb_min_y <= clip_min_y;
            o_bb_max_x <= clip_max_x;
            o_bb_max_y <= clip_max_y;
            for (int k = 0; k < `RS_NUM_LANES; k++) begin
                if (raster_geom_pkg::lane_t'(k) == raster_geom_pkg::LANE_AREA) begin
                    // Edge v0 to v1 taken at v2
                    o_lane_ax[k] <= vx[0];
                    o_lane_ay[k] <= vy[0];
                    o_lane_bx[k] <= vx[1];
                    o_lane_by[k] <= vy[1];
                    o_lane_px[k] <= vx[2];
                    o_lane_py[k] <= vy[2];
                end else begin
                    o_lane_ax[k] <= vx[k % 3];
                    o_lane_ay[k] <= vy[k % 3];
                    o_lane_bx[k] <= vx[(k + 1) % 3];
                    o_lane_by[k] <= vy[(k + 1) % 3];
                    o_lane_px[k] <= clip_min_x;
                    o_lane_py[k] <= clip_min_y;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/tri_emit.sv
`timescale 1ns/100ps
`default_nettype none

module tri_emit (
    input  wire logic                       clk,
    input  wire logic                       rstn,
    input  wire logic                       i_lane_done,
    input  wire raster_geom_pkg::edge_val_t i_area,
    input  wire raster_geom_pkg::edge_val_t i_edge_val [3],
    input  wire raster_geom_pkg::coord_t    i_edge_dx [3],
    input  wire raster_geom_pkg::coord_t    i_edge_dy [3],
    input  wire raster_geom_pkg::coord_t    i_bb_min_x,
    input  wire raster_geom_pkg::coord_t    i_bb_min_y,
    input  wire raster_geom_pkg::coord_t    i_bb_max_x,
    input  wire raster_geom_pkg::coord_t    i_bb_max_y,
    input  wire logic                       i_bb_valid,
    input  wire logic                       i_last,
    input  wire logic                       i_next,
    output logic                            o_retire,
    output raster_geom_pkg::coord_t         o_bb_min_x,
    output raster_geom_pkg::coord_t         o_bb_min_y,
    output raster_geom_pkg::coord_t         o_bb_max_x,
    output raster_geom_pkg::coord_t         o_bb_max_y,
    output raster_geom_pkg::edge_val_t      o_edge_val0,
    output raster_geom_pkg::edge_val_t      o_edge_val1,
    output raster_geom_pkg::edge_val_t      o_edge_val2,
    output raster_geom_pkg::coord_t         o_edge_dx0,
    output raster_geom_pkg::coord_t         o_edge_dx1,
    output raster_geom_pkg::coord_t         o_edge_dx2,
    output raster_geom_pkg::coord_t         o_edge_dy0,
    output raster_geom_pkg::coord_t         o_edge_dy1,
    output raster_geom_pkg::coord_t         o_edge_dy2,
    output raster_seq_pkg::tri_id_t         o_id,
    output logic                            o_dv,
    output logic                            o_last,
    output logic                            o_finished_with_cull
);

    raster_seq_pkg::emit_state_t state;
    raster_seq_pkg::tri_id_t     next_id;
    logic                        cull;
    logic                        fire;

    // Back-facing, degenerate or fully off screen
    assign cull = (i_area <= 0) || !i_bb_valid;

    // Lane and box registers hold until retire, so HOLD reads them directly
    assign fire = i_next && ((state == raster_seq_pkg::EMIT_IDLE && i_lane_done) ||
                             state == raster_seq_pkg::EMIT_HOLD);

    assign o_retire = (state == raster_seq_pkg::EMIT_WAIT);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state                <= raster_seq_pkg::EMIT_IDLE;
            next_id              <= '0;
            o_dv                 <= 1'b0;
            o_last               <= 1'b0;
            o_finished_with_cull <= 1'b0;
        end else begin
            o_dv                 <= fire && !cull;
            o_finished_with_cull <= fire && cull && i_last;
            case (state)
                raster_seq_pkg::EMIT_IDLE: begin
                    if (i_lane_done) begin
                        state <= i_next ? raster_seq_pkg::EMIT_WAIT : raster_seq_pkg::EMIT_HOLD;
                    end
                end
                raster_seq_pkg::EMIT_HOLD: begin
                    if (i_next) begin
                        state <= raster_seq_pkg::EMIT_WAIT;
                    end
                end
                default: begin
                    state <= raster_seq_pkg::EMIT_IDLE;
                end
            endcase
            if (fire) begin
                // A last triangle restarts the sequence even when dropped
                if (i_last) begin
                    next_id <= '0;
                end else if (!cull) begin
                    next_id <= next_id + 1'b1;
                end
                if (!cull) begin
                    o_last <= i_last;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire && !cull) begin
            o_bb_min_x  <= i_bb_min_x;
            o_bb_min_y  <= i_bb_min_y;
            o_bb_max_x  <= i_bb_max_x;
            o_bb_max_y  <= i_bb_max_y;
            o_edge_val0 <= i_edge_val[0];
            o_edge_val1 <= i_edge_val[1];
            o_edge_val2 <= i_edge_val[2];
            o_edge_dx0  <= i_edge_dx[0];
            o_edge_dx1  <= i_edge_dx[1];
            o_edge_dx2  <= i_edge_dx[2];
            o_edge_dy0  <= i_edge_dy[0];
            o_edge_dy1  <= i_edge_dy[1];
            o_edge_dy2  <= i_edge_dy[2];
            o_id        <= next_id;
        end
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+design
design/raster_geom_pkg.sv
design/raster_seq_pkg.sv
design/tri_capture.sv
design/edge_eval.sv
design/tri_emit.sv
design/raster_setup.sv
verif/raster_setup_tb.sv

//--- verif/raster_setup_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "raster_params.svh"

module raster_setup_tb;

    localparam int CLK_PERIOD  = 4;
    localparam int NUM_VISIBLE = 20;
    localparam int NUM_STALLED = 16;
    // Clip, cull and id tests use fixed lists
    localparam int NUM_FIXED   = 20;
    localparam int NUM_TRIS    = NUM_VISIBLE + NUM_STALLED + NUM_FIXED;

    logic                       clk;
    logic                       rstn;
    logic                       o_ready;
    logic                       i_next;
    raster_geom_pkg::coord_t    i_v0_x;
    raster_geom_pkg::coord_t    i_v0_y;
    raster_geom_pkg::coord_t    i_v1_x;
    raster_geom_pkg::coord_t    i_v1_y;
    raster_geom_pkg::coord_t    i_v2_x;
    raster_geom_pkg::coord_t    i_v2_y;
    logic                       i_triangle_dv;
    logic                       i_triangle_last;
    raster_geom_pkg::coord_t    o_bb_min_x;
    raster_geom_pkg::coord_t    o_bb_min_y;
    raster_geom_pkg::coord_t    o_bb_max_x;
    raster_geom_pkg::coord_t    o_bb_max_y;
    raster_geom_pkg::edge_val_t o_edge_val0;
    raster_geom_pkg::edge_val_t o_edge_val1;
    raster_geom_pkg::edge_val_t o_edge_val2;
    raster_geom_pkg::coord_t    o_edge_dx0;
    raster_geom_pkg::coord_t    o_edge_dx1;
    raster_geom_pkg::coord_t    o_edge_dx2;
    raster_geom_pkg::coord_t    o_edge_dy0;
    raster_geom_pkg::coord_t    o_edge_dy1;
    raster_geom_pkg::coord_t    o_edge_dy2;
    raster_seq_pkg::tri_id_t    o_id;
    logic                       o_dv;
    logic                       o_last;
    logic                       o_finished_with_cull;

    // Reference model results for the triangle in flight
    longint exp_min_x;
    longint exp_min_y;
    longint exp_max_x;
    longint exp_max_y;
    longint exp_val [3];
    longint exp_dx [3];
    longint exp_dy [3];
    bit     exp_cull;
    longint exp_id;

    raster_setup i_raster_setup (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input longint expected, input longint actual);
        assert (expected == actual) else
            report_failure($sformatf("ERROR %s expected %0d actual %0d", name, expected, actual));
    endtask

    function automatic longint edge_fn(input longint ax, ay, bx, by, px, py);
        return (px - ax) * (by - ay) - (py - ay) * (bx - ax);
    endfunction

    function automatic int rand_between(input int lo, input int hi);
        return lo + int'($urandom_range(hi - lo));
    endfunction

    task automatic compute_expected(input int x0, y0, x1, y1, x2, y2);
        longint vx [3];
        longint vy [3];
        longint lo_x;
        longint lo_y;
        longint hi_x;
        longint hi_y;
        int     i;
        vx = '{longint'(x0), longint'(x1), longint'(x2)};
        vy = '{longint'(y0), longint'(y1), longint'(y2)};
        lo_x = vx[0];
        hi_x = vx[0];
        lo_y = vy[0];
        hi_y = vy[0];
        for (i = 1; i < 3; i++) begin
            lo_x = (vx[i] < lo_x) ? vx[i] : lo_x;
            hi_x = (vx[i] > hi_x) ? vx[i] : hi_x;
            lo_y = (vy[i] < lo_y) ? vy[i] : lo_y;
            hi_y = (vy[i] > hi_y) ? vy[i] : hi_y;
        end
        exp_min_x = (lo_x < 0) ? 0 : lo_x;
        exp_min_y = (lo_y < 0) ? 0 : lo_y;
        exp_max_x = (hi_x > `RS_SCREEN_W) ? `RS_SCREEN_W : hi_x;
        exp_max_y = (hi_y > `RS_SCREEN_H) ? `RS_SCREEN_H : hi_y;
        exp_cull = (edge_fn(vx[0], vy[0], vx[1], vy[1], vx[2], vy[2]) <= 0) ||
                   (exp_min_x > exp_max_x) || (exp_min_y > exp_max_y);
        // Edge i runs from vertex i to the next one, taken at the box corner
        for (i = 0; i < 3; i++) begin
            exp_val[i] = edge_fn(vx[i], vy[i], vx[(i + 1) % 3], vy[(i + 1) % 3],
                                 exp_min_x, exp_min_y);
            exp_dx[i]  = vy[(i + 1) % 3] - vy[i];
            exp_dy[i]  = vx[i] - vx[(i + 1) % 3];
        end
    endtask

    task automatic check_outputs(input string name, input bit last);
        check_value({name, " bb_min_x"}, exp_min_x, longint'(o_bb_min_x));
        check_value({name, " bb_min_y"}, exp_min_y, longint'(o_bb_min_y));
        check_value({name, " bb_max_x"}, exp_max_x, longint'(o_bb_max_x));
        check_value({name, " bb_max_y"}, exp_max_y, longint'(o_bb_max_y));
        check_value({name, " edge_val0"}, exp_val[0], longint'(o_edge_val0));
        check_value({name, " edge_val1"}, exp_val[1], longint'(o_edge_val1));
        check_value({name, " edge_val2"}, exp_val[2], longint'(o_edge_val2));
        check_value({name, " edge_dx0"}, exp_dx[0], longint'(o_edge_dx0));
        check_value({name, " edge_dx1"}, exp_dx[1], longint'(o_edge_dx1));
        check_value({name, " edge_dx2"}, exp_dx[2], longint'(o_edge_dx2));
        check_value({name, " edge_dy0"}, exp_dy[0], longint'(o_edge_dy0));
        check_value({name, " edge_dy1"}, exp_dy[1], longint'(o_edge_dy1));
        check_value({name, " edge_dy2"}, exp_dy[2], longint'(o_edge_dy2));
        check_value({name, " id"}, exp_id, longint'(o_id));
        check_value({name, " last"}, longint'(last), longint'(o_last));
    endtask

    // Sends one triangle and follows it until o_ready returns
    task automatic run_triangle(input string name, input int x0, y0, x1, y1, x2, y2,
                                input bit last, input bit stall);
        int dv_seen;
        int fin_seen;
        int hold;
        compute_expected(x0, y0, x1, y1, x2, y2);
        dv_seen  = 0;
        fin_seen = 0;
        hold     = stall ? rand_between(1, 8) : 0;
        while (!o_ready) begin
            @(posedge clk);
            #1;
        end
        i_triangle_dv   = 1'b1;
        i_triangle_last = last;
        i_v0_x          = raster_geom_pkg::coord_t'(x0);
        i_v0_y          = raster_geom_pkg::coord_t'(y0);
        i_v1_x          = raster_geom_pkg::coord_t'(x1);
        i_v1_y          = raster_geom_pkg::coord_t'(y1);
        i_v2_x          = raster_geom_pkg::coord_t'(x2);
        i_v2_y          = raster_geom_pkg::coord_t'(y2);
        @(posedge clk);
        #1;
        i_triangle_dv = 1'b0;
        do begin
            i_next = (hold == 0);
            if (hold > 0) begin
                hold--;
            end
            // Strobes with junk vertices while busy must be ignored
            if (stall) begin
                i_triangle_dv = ($urandom_range(1) == 1);
                i_v0_x        = raster_geom_pkg::coord_t'(rand_between(-50, 50));
                i_v2_y        = raster_geom_pkg::coord_t'(rand_between(-50, 50));
            end
            @(posedge clk);
            #1;
            if (o_dv) begin
                dv_seen++;
                check_outputs(name, last);
            end
            if (o_finished_with_cull) begin
                fin_seen++;
            end
        end while (!o_ready);
        i_triangle_dv = 1'b0;
        i_next        = 1'b1;
        check_value({name, " dv pulses"}, exp_cull ? 0 : 1, longint'(dv_seen));
        check_value({name, " cull pulses"}, (exp_cull && last) ? 1 : 0, longint'(fin_seen));
        if (last) begin
            exp_id = 0;
        end else if (!exp_cull) begin
            exp_id++;
        end
    endtask

    task automatic run_ccw(input string name, input int x0, y0, x1, y1, x2, y2,
                           input bit last, input bit stall);
        if (edge_fn(x0, y0, x1, y1, x2, y2) < 0) begin
            run_triangle(name, x0, y0, x2, y2, x1, y1, last, stall);
        end else begin
            run_triangle(name, x0, y0, x1, y1, x2, y2, last, stall);
        end
    endtask

    task automatic run_random(input string name, input bit clockwise, input bit last,
                              input bit stall);
        int     c [6];
        int     i;
        longint area;
        do begin
            for (i = 0; i < 6; i++) begin
                c[i] = rand_between(0, (i % 2 == 1) ? `RS_SCREEN_H : `RS_SCREEN_W);
            end
            area = edge_fn(c[0], c[1], c[2], c[3], c[4], c[5]);
        end while (area == 0);
        if ((area < 0) != clockwise) begin
            run_triangle(name, c[0], c[1], c[4], c[5], c[2], c[3], last, stall);
        end else begin
            run_triangle(name, c[0], c[1], c[2], c[3], c[4], c[5], last, stall);
        end
    endtask

    // One result per retire, and nothing leaves while held
    assert property (@(posedge clk) disable iff (!rstn) o_dv |=> !o_dv)
        else report_failure("o_dv was high for two consecutive cycles");
    assert property (@(posedge clk) disable iff (!rstn)
                     !i_next |=> !o_dv && !o_finished_with_cull)
        else report_failure("A result pulse appeared while i_next was low");
    assert property (@(posedge clk) disable iff (!rstn) !(o_dv && o_finished_with_cull))
        else report_failure("o_dv and o_finished_with_cull were high together");

    initial begin
        #(CLK_PERIOD * (NUM_TRIS * 20 + 200));
        report_failure("Watchdog timeout, the run did not finish in time");
    end

    initial begin
        int seed_init;
        int n;
        rstn            = 1'b0;
        i_next          = 1'b1;
        i_triangle_dv   = 1'b0;
        i_triangle_last = 1'b0;
        i_v0_x          = '0;
        i_v0_y          = '0;
        i_v1_x          = '0;
        i_v1_y          = '0;
        i_v2_x          = '0;
        i_v2_y          = '0;
        exp_id          = 0;
        seed_init       = $urandom(32'h443c);
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(posedge clk);
        #1;
        check_value("reset o_dv", 0, longint'(o_dv));
        check_value("reset o_last", 0, longint'(o_last));
        check_value("reset o_finished_with_cull", 0, longint'(o_finished_with_cull));
        check_value("reset o_ready", 1, longint'(o_ready));

        for (n = 0; n < NUM_VISIBLE; n++) begin
            run_random("visible", 1'b0, (n % 10) == 9, 1'b0);
        end

        run_ccw("clip_left", -100, 50, 100, 60, 50, 200, 1'b0, 1'b0);
        run_ccw("clip_right", 250, 40, 450, 100, 280, 250, 1'b0, 1'b0);
        run_ccw("clip_top", 100, -80, 200, 100, 30, 120, 1'b0, 1'b0);
        run_ccw("clip_bottom", 60, 200, 250, 450, 150, 260, 1'b0, 1'b0);
        run_ccw("clip_all", -300, -300, 700, -200, 100, 700, 1'b0, 1'b0);
        run_ccw("off_left", -300, 10, -50, 40, -200, 200, 1'b0, 1'b0);
        run_ccw("off_bottom", 10, 400, 200, 500, 100, 600, 1'b0, 1'b0);

        run_random("clockwise", 1'b1, 1'b0, 1'b0);
        run_random("clockwise", 1'b1, 1'b0, 1'b0);
        run_triangle("degenerate", 10, 10, 50, 50, 100, 100, 1'b0, 1'b0);
        run_triangle("repeated", 30, 40, 30, 40, 200, 10, 1'b0, 1'b0);
        // Culled triangles leave the id where the last emitted one put it
        run_random("id_after_cull", 1'b0, 1'b0, 1'b0);
        run_random("clockwise_last", 1'b1, 1'b1, 1'b0);
        run_triangle("degenerate_last", 5, 5, 5, 5, 5, 5, 1'b1, 1'b0);

        // Ids restart after a culled last and after an emitted last
        for (n = 0; n < 5; n++) begin
            run_random("id_seq", 1'b0, n == 3, 1'b0);
        end
        run_random("id_after_last", 1'b0, 1'b0, 1'b0);

        for (n = 0; n < NUM_STALLED; n++) begin
            run_random("stall", 1'b0, n == NUM_STALLED - 1, 1'b1);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
